/* Bender.yml */
package:
  name: muldiv_unit

sources:
  - hdl/riscv_isa_pkg.sv
  - hdl/muldiv_pkg.sv
  - hdl/fu_issue_if.sv
  - hdl/div_if.sv
  - hdl/mul_pipe.sv
  - hdl/serial_divider.sv
  - hdl/div_word_adapter.sv
  - hdl/muldiv_unit.sv
  - target: test
    files:
      - dv/muldiv_tb.sv

/* dv/muldiv_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb import riscv_isa_pkg::*; import muldiv_pkg::*; ();

    localparam int unsigned N_OPS = 40 + 12 + 12 + 12 + (DIV_CYCLES + 9) + 2;
    localparam int unsigned WATCHDOG_CYCLES = N_OPS * (DIV_CYCLES + 10) + 200;
    localparam xlen_t MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic      clk_i;
    logic      rst_ni;
    logic      flush_i;
    logic      valid_i;
    trans_id_t trans_id_i;
    fu_op_t    operation_i;
    xlen_t     operand_a_i;
    xlen_t     operand_b_i;
    logic      valid_o;
    logic      ready_o;
    trans_id_t trans_id_o;
    xlen_t     result_o;

    // expected results in issue order, exp_cyc is -1 for divisions
    trans_id_t   exp_id [$];
    xlen_t       exp_val [$];
    int          exp_cyc [$];
    bit          used [$];
    int          exp_n = 0;
    // results seen on the output
    trans_id_t   got_id [$];
    xlen_t       got_val [$];
    int          got_cyc [$];
    int          got_n = 0;
    bit          pending [2**TRANS_ID_BITS];
    int          cyc = 0;
    int unsigned seed_val;
    string       test_name;

    fu_op_t mul_ops [5] = '{MUL, MULH, MULHU, MULHSU, MULW};
    fu_op_t div_ops [4] = '{DIV, DIVU, REM, REMU};
    fu_op_t wdiv_ops [4] = '{DIVW, DIVUW, REMW, REMUW};
    xlen_t  corner_a [4] = '{'0, '1, MIN_NEG, MIN_NEG};
    xlen_t  corner_b [4] = '{'1, '1, MIN_NEG, '1};

    muldiv_unit uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    // ------------------------------------------------------------------------
    // reference model, 128-bit arithmetic on extended operands
    // ------------------------------------------------------------------------
    function automatic xlen_t ref_result(input fu_op_t op, input xlen_t a, input xlen_t b);
        logic signed [127:0] wa;
        logic signed [127:0] wb;
        logic signed [127:0] r;
        logic                sa;
        logic                sb;
        sa = op inside {MULH, MULHSU} || is_signed_div(op);
        sb = op == MULH || is_signed_div(op);
        if (is_div_op(op) && is_word_op(op)) begin
            // word divides see only the low halves
            wa = sa ? {{96{a[31]}}, a[31:0]} : {96'b0, a[31:0]};
            wb = sb ? {{96{b[31]}}, b[31:0]} : {96'b0, b[31:0]};
        end else begin
            wa = sa ? {{64{a[63]}}, a} : {64'b0, a};
            wb = sb ? {{64{b[63]}}, b} : {64'b0, b};
        end
        if (is_mul_op(op)) begin
            r = wa * wb;
        end else if (wb == 0) begin
            // x/0 gives all ones, x%0 gives x
            r = is_rem(op) ? wa : '1;
        end else begin
            // overflow needs no special path at 128 bits, truncation gives the dividend
            r = is_rem(op) ? wa % wb : wa / wb;
        end
        if (is_word_op(op)) begin
            return {{32{r[31]}}, r[31:0]};
        end
        return (op inside {MULH, MULHU, MULHSU}) ? r[127:64] : r[63:0];
    endfunction

    function automatic xlen_t rand64();
        return {$urandom, $urandom};
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("error %s: result expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_trans_id(input string name, input trans_id_t exp, input trans_id_t act);
        if (act !== exp) begin
            $display("error %s: trans_id expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // every result must belong to an outstanding id
    always @(negedge clk_i) begin
        if (rst_ni && valid_o) begin
            if (!pending[trans_id_o]) begin
                $display("a result with trans_id %0d came out but none was outstanding",
                         trans_id_o);
                abort_run();
            end
            pending[trans_id_o] = 1'b0;
            got_id.push_back(trans_id_o);
            got_val.push_back(result_o);
            got_cyc.push_back(cyc);
            got_n++;
        end
    end

    // ------------------------------------------------------------------------
    // driving and collecting
    // ------------------------------------------------------------------------
    task automatic issue_op(input fu_op_t op, input xlen_t a, input xlen_t b,
                            input trans_id_t id);
        @(negedge clk_i);
        valid_i     = 1'b1;
        operation_i = op;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = id;
        exp_id.push_back(id);
        exp_val.push_back(ref_result(op, a, b));
        exp_cyc.push_back(is_mul_op(op) ? cyc : -1);
        used.push_back(1'b0);
        exp_n++;
        pending[id] = 1'b1;
    endtask

    task automatic go_idle();
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic wait_ready();
        while (!ready_o) @(negedge clk_i);
    endtask

    task automatic clear_expect();
        exp_id.delete();
        exp_val.delete();
        exp_cyc.delete();
        used.delete();
        got_id.delete();
        got_val.delete();
        got_cyc.delete();
        exp_n = 0;
        got_n = 0;
    endtask

    task automatic check_outputs(input bit in_order);
        int j;
        wait (got_n >= exp_n);
        for (int i = 0; i < got_n; i++) begin
            if (in_order) check_trans_id(test_name, exp_id[i], got_id[i]);
            // oldest unused entry with this id, ids get reused
            j = 0;
            while (j < exp_n && (used[j] || exp_id[j] != got_id[i])) j++;
            used[j] = 1'b1;
            check_result(test_name, exp_val[j], got_val[i]);
            if (exp_cyc[j] >= 0 && got_cyc[i] != exp_cyc[j] + 2) begin
                $display("multiply with trans_id %0d in %s did not finish 2 cycles after issue",
                         got_id[i], test_name);
                abort_run();
            end
        end
        clear_expect();
    endtask

    task automatic run_div(input fu_op_t op, input xlen_t a, input xlen_t b, input trans_id_t id);
        wait_ready();
        issue_op(op, a, b, id);
        go_idle();
        if (ready_o) begin
            $display("ready_o stayed high after a division was accepted in %s", test_name);
            abort_run();
        end
        check_outputs(1'b1);
        wait_ready();
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_multiplies();
        xlen_t a;
        xlen_t b;
        int    n;
        test_name = "multiplies";
        n = 0;
        // corner pairs first, then random, all back to back
        for (int s = 0; s < 8; s++) begin
            a = (s < 4) ? corner_a[s] : rand64();
            b = (s < 4) ? corner_b[s] : rand64();
            foreach (mul_ops[k]) begin
                issue_op(mul_ops[k], a, b, trans_id_t'(n));
                n++;
            end
        end
        go_idle();
        check_outputs(1'b1);
    endtask

    task automatic test_divides();
        test_name = "full divides";
        for (int r = 0; r < 3; r++)
            foreach (div_ops[k]) run_div(div_ops[k], rand64(), rand64() >> (24 * r), 3'(k));
        test_name = "special cases";
        foreach (div_ops[k]) run_div(div_ops[k], rand64(), '0, 3'd1);
        foreach (wdiv_ops[k]) run_div(wdiv_ops[k], rand64(), {$urandom, 32'h0}, 3'd2);
        run_div(DIV, MIN_NEG, '1, 3'd3);
        run_div(REM, MIN_NEG, '1, 3'd4);
        run_div(DIVW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff}, 3'd5);
        run_div(REMW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff}, 3'd6);
        // junk in the upper halves of both operands
        test_name = "word divides";
        for (int r = 0; r < 3; r++)
            foreach (wdiv_ops[k])
                run_div(wdiv_ops[k], rand64(), {$urandom, 32'($urandom >> (12 * r))}, 3'(k));
    endtask

    task automatic test_collision();
        test_name = "collision";
        wait_ready();
        issue_op(DIV, rand64(), rand64() >> 20, 3'd0);
        // multiplies keep the output busy across the divider finish
        for (int k = 0; k < DIV_CYCLES + 8; k++)
            issue_op(mul_ops[k % 5], rand64(), rand64(), trans_id_t'(k % 7 + 1));
        go_idle();
        check_outputs(1'b0);
        wait_ready();
    endtask

    task automatic test_flush();
        test_name = "flush";
        wait_ready();
        issue_op(DIVU, rand64(), rand64() >> 8, 3'd5);
        go_idle();
        repeat (DIV_CYCLES / 2) @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        // id 5 is no longer outstanding, so the monitor trips on any late result
        pending[5] = 1'b0;
        clear_expect();
        wait_ready();
        run_div(DIV, rand64(), rand64() >> 30, 3'd6);
    endtask

    initial begin
        seed_val    = $urandom(59);
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        trans_id_i  = '0;
        operation_i = MUL;
        operand_a_i = '0;
        operand_b_i = '0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        if (!ready_o || valid_o) begin
            $display("after reset ready_o is not high or valid_o is not low");
            abort_run();
        end
        test_multiplies();
        test_divides();
        test_collision();
        test_flush();
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog sized from the number of issued operations
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired, the DUT stopped returning results");
        abort_run();
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/riscv_isa_pkg.sv
hdl/muldiv_pkg.sv
hdl/fu_issue_if.sv
hdl/div_if.sv
hdl/mul_pipe.sv
hdl/serial_divider.sv
hdl/div_word_adapter.sv
hdl/muldiv_unit.sv
dv/muldiv_tb.sv

/* hdl/div_if.sv */
`timescale 1ns/100ps
`default_nettype none

// request and result handshake between divider front end and serial divider
interface div_if import riscv_isa_pkg::*, muldiv_pkg::*; ();

    // ------------------------------------------------------------------------
    // request side, transfers on in_valid & in_ready
    // ------------------------------------------------------------------------
    logic      in_valid;
    logic      in_ready;
    xlen_t     op_a;
    xlen_t     op_b;
    logic      is_signed;
    logic      is_rem;
    trans_id_t id;

    // ------------------------------------------------------------------------
    // result side, held stable until out_ready
    // ------------------------------------------------------------------------
    logic      out_valid;
    logic      out_ready;
    xlen_t     result;
    trans_id_t out_id;

    modport master (
        output in_valid, op_a, op_b, is_signed, is_rem, id, out_ready,
        input  in_ready, out_valid, result, out_id
    );

    modport slave (
        input  in_valid, op_a, op_b, is_signed, is_rem, id, out_ready,
        output in_ready, out_valid, result, out_id
    );

endinterface

`default_nettype wire

/* hdl/div_word_adapter.sv */
`timescale 1ns/100ps
`default_nettype none

module div_word_adapter import riscv_isa_pkg::*; import muldiv_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    fu_issue_if.div_sink issue,
    input  logic         result_ready_i,
    output logic         ready_o,
    output logic         valid_o,
    output trans_id_t    trans_id_o,
    output xlen_t        result_o
);
    logic  div_issue;
    logic  word_op;
    logic  word_q;

    div_if div ();

    assign div_issue = issue.valid & is_div_op(issue.operation);
    assign word_op   = is_word_op(issue.operation);

    // operands stay at zero unless a division is issued
    always_comb begin
        div.op_a = '0;
        div.op_b = '0;
        if (div_issue) begin
            if (word_op && is_signed_div(issue.operation)) begin
                div.op_a = sext32(issue.operand_a);
                div.op_b = sext32(issue.operand_b);
            end else if (word_op) begin
                // unsigned word forms, upper halves cleared
                div.op_a = {{(XLEN-32){1'b0}}, issue.operand_a[31:0]};
                div.op_b = {{(XLEN-32){1'b0}}, issue.operand_b[31:0]};
            end else begin
                div.op_a = issue.operand_a;
                div.op_b = issue.operand_b;
            end
        end
    end

    assign div.in_valid  = div_issue;
    assign div.is_signed = is_signed_div(issue.operation);
    assign div.is_rem    = is_rem(issue.operation);
    assign div.id        = issue.trans_id;
    assign div.out_ready = result_ready_i;

    // single division in flight, so one flag is enough
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            word_q <= 1'b0;
        end else if (div.in_valid && div.in_ready) begin
            word_q <= word_op;
        end
    end

    serial_divider i_serial_divider (
        .clk_i   ( clk_i   ),
        .rst_ni  ( rst_ni  ),
        .flush_i ( flush_i ),
        .div     ( div     )
    );

    assign ready_o    = div.in_ready;
    assign valid_o    = div.out_valid;
    assign trans_id_o = div.out_id;
    // word results come back as 32-bit values in a 64-bit word
    assign result_o   = word_q ? sext32(div.result) : div.result;

endmodule

`default_nettype wire

/* hdl/fu_issue_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one issued request, fanned out from the unit top to both datapaths
interface fu_issue_if import riscv_isa_pkg::*, muldiv_pkg::*; ();

    // qualified by the top: no flush and a known op class
    logic      valid;
    trans_id_t trans_id;
    fu_op_t    operation;
    xlen_t     operand_a;
    xlen_t     operand_b;

    modport issuer (
        output valid, trans_id, operation, operand_a, operand_b
    );

    modport mul_sink (
        input valid, trans_id, operation, operand_a, operand_b
    );

    modport div_sink (
        input valid, trans_id, operation, operand_a, operand_b
    );

endinterface

`default_nettype wire

/* hdl/mul_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module mul_pipe import riscv_isa_pkg::*; import muldiv_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    fu_issue_if.mul_sink issue,
    output logic        valid_o,
    output trans_id_t   trans_id_o,
    output xlen_t       result_o
);
    // stage 1
    logic                valid1_q;
    trans_id_t           id1_q;
    xlen_t               a1_q;
    xlen_t               b1_q;
    logic                sa1_q;
    logic                sb1_q;
    logic                high1_q;
    logic                word1_q;
    // stage 2
    logic                valid2_q;
    trans_id_t           id2_q;
    logic                high2_q;
    logic                word2_q;
    logic [2*XLEN-1:0]   prod2_q;

    logic                accept;
    logic [2*XLEN-1:0]   prod_d;

    // interface valid already excludes flush, pick out the multiplies here
    assign accept = issue.valid & is_mul_op(issue.operation);

    // one extra bit per operand carries its sign for MULH / MULHSU
    assign prod_d = $signed({sa1_q & a1_q[XLEN-1], a1_q}) *
                    $signed({sb1_q & b1_q[XLEN-1], b1_q});

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else begin
            valid1_q <= accept;
            valid2_q <= valid1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            id1_q   <= issue.trans_id;
            a1_q    <= issue.operand_a;
            b1_q    <= issue.operand_b;
            sa1_q   <= issue.operation inside {MULH, MULHSU};
            sb1_q   <= issue.operation == MULH;
            high1_q <= issue.operation inside {MULH, MULHU, MULHSU};
            word1_q <= is_word_op(issue.operation);
        end
        if (valid1_q) begin
            id2_q   <= id1_q;
            prod2_q <= prod_d;
            high2_q <= high1_q;
            word2_q <= word1_q;
        end
    end

    // product half select, MULW takes the low 32 bits
    assign valid_o    = valid2_q;
    assign trans_id_o = id2_q;
    assign result_o   = word2_q ? sext32(prod2_q[XLEN-1:0]) :
                        high2_q ? prod2_q[2*XLEN-1:XLEN] : prod2_q[XLEN-1:0];

endmodule

`default_nettype wire

/* hdl/muldiv_pkg.sv */
`default_nettype none

// ---------------------------------------------------------------------------
// multiply/divide unit definitions
// ---------------------------------------------------------------------------
package muldiv_pkg;

    import riscv_isa_pkg::*;

    // transaction id travelling with each issued op
    localparam int unsigned TRANS_ID_BITS = 3;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // nominal divider iterations, one quotient bit each
    localparam int unsigned DIV_CYCLES = XLEN;
    localparam int unsigned DIV_CNT_BITS = $clog2(DIV_CYCLES);

    // divider state encoding
    localparam logic [1:0] DIV_IDLE   = 2'd0;
    localparam logic [1:0] DIV_DIVIDE = 2'd1;
    localparam logic [1:0] DIV_FINISH = 2'd2;

    typedef enum logic [3:0] {
        MUL, MULH, MULHU, MULHSU, MULW,
        DIV, DIVU, DIVW, DIVUW,
        REM, REMU, REMW, REMUW
    } fu_op_t;

    // ops handled by the pipelined multiplier
    function automatic logic is_mul_op(input fu_op_t op);
        return op inside {MUL, MULH, MULHU, MULHSU, MULW};
    endfunction

    // ops handled by the serial divider
    function automatic logic is_div_op(input fu_op_t op);
        return op inside {DIV, DIVU, DIVW, DIVUW, REM, REMU, REMW, REMUW};
    endfunction

    // 32-bit forms, result gets sign-extended
    function automatic logic is_word_op(input fu_op_t op);
        return op inside {MULW, DIVW, DIVUW, REMW, REMUW};
    endfunction

    function automatic logic is_signed_div(input fu_op_t op);
        return op inside {DIV, DIVW, REM, REMW};
    endfunction

    function automatic logic is_rem(input fu_op_t op);
        return op inside {REM, REMU, REMW, REMUW};
    endfunction

endpackage

`default_nettype wire

/* hdl/muldiv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit import riscv_isa_pkg::*; import muldiv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      valid_i,
    input  trans_id_t trans_id_i,
    input  fu_op_t    operation_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    output logic      valid_o,
    output logic      ready_o,
    output trans_id_t trans_id_o,
    output xlen_t     result_o
);
    logic      mul_valid;
    trans_id_t mul_id;
    xlen_t     mul_result;
    logic      div_valid;
    trans_id_t div_id;
    xlen_t     div_result;

    fu_issue_if issue ();

    // ------------------------------------------------------------------------
    // issue
    // ------------------------------------------------------------------------
    // drop requests under flush and opcodes outside both classes
    assign issue.valid     = valid_i & ~flush_i &
                             (is_mul_op(operation_i) | is_div_op(operation_i));
    assign issue.trans_id  = trans_id_i;
    assign issue.operation = operation_i;
    assign issue.operand_a = operand_a_i;
    assign issue.operand_b = operand_b_i;

    mul_pipe i_mul_pipe (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .issue      ( issue      ),
        .valid_o    ( mul_valid  ),
        .trans_id_o ( mul_id     ),
        .result_o   ( mul_result )
    );

    // divider result is held back while the multiplier owns the output
    div_word_adapter i_div_word_adapter (
        .clk_i          ( clk_i      ),
        .rst_ni         ( rst_ni     ),
        .flush_i        ( flush_i    ),
        .issue          ( issue      ),
        .result_ready_i ( ~mul_valid ),
        .ready_o        ( ready_o    ),
        .valid_o        ( div_valid  ),
        .trans_id_o     ( div_id     ),
        .result_o       ( div_result )
    );

    // ------------------------------------------------------------------------
    // output arbitration, multiplier first
    // ------------------------------------------------------------------------
    assign valid_o    = mul_valid | div_valid;
    assign trans_id_o = mul_valid ? mul_id : div_id;
    assign result_o   = mul_valid ? mul_result : div_result;

endmodule

`default_nettype wire

/* hdl/riscv_isa_pkg.sv */
`default_nettype none

// ---------------------------------------------------------------------------
// ISA-level definitions shared by the integer datapath
// ---------------------------------------------------------------------------
package riscv_isa_pkg;

    // register width of the RV64 integer file
    localparam int unsigned XLEN = 64;

    // one architectural register word
    typedef logic [XLEN-1:0] xlen_t;

    // sign-extend the low 32 bits of a word to full register width
    // used by all *W forms to produce their 64-bit result
    function automatic xlen_t sext32(input xlen_t word);
        xlen_t ext;
        ext = {{(XLEN-32){word[31]}}, word[31:0]};
        return ext;
    endfunction

endpackage

`default_nettype wire

/* hdl/serial_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_divider import riscv_isa_pkg::*; import muldiv_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    div_if.slave div
);
    // control
    logic [1:0]              state_q;
    logic [1:0]              state_d;
    logic [DIV_CNT_BITS-1:0] cnt_q;
    // payload
    xlen_t                   rem_q;
    xlen_t                   quo_q;
    xlen_t                   dvs_q;
    logic                    quo_neg_q;
    logic                    rem_neg_q;
    logic                    want_rem_q;
    trans_id_t               id_q;

    logic                    accept;
    logic                    a_neg;
    logic                    b_neg;
    logic                    b_zero;
    xlen_t                   mag_a;
    xlen_t                   mag_b;
    logic [XLEN:0]           partial;
    logic [XLEN+1:0]         diff;
    logic                    fits;

    assign accept = div.in_valid & div.in_ready;

    // ------------------------------------------------------------------------
    // operand magnitudes and result signs
    // ------------------------------------------------------------------------
    assign a_neg  = div.is_signed & div.op_a[XLEN-1];
    assign b_neg  = div.is_signed & div.op_b[XLEN-1];
    assign b_zero = div.op_b == '0;

    // most negative value maps onto itself, which is the right unsigned magnitude
    assign mag_a = a_neg ? -div.op_a : div.op_a;
    assign mag_b = b_neg ? -div.op_b : div.op_b;

    // ------------------------------------------------------------------------
    // restoring step
    // ------------------------------------------------------------------------
    // shift next dividend bit into the partial remainder
    assign partial = {rem_q, quo_q[XLEN-1]};
    assign diff    = {1'b0, partial} - {2'b00, dvs_q};
    // no borrow means the divisor fits, quotient bit is one
    assign fits    = ~diff[XLEN+1];

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            DIV_IDLE: begin
                if (accept) begin
                    state_d = DIV_DIVIDE;
                end
            end
            DIV_DIVIDE: begin
                // last iteration
                if (cnt_q == '0) begin
                    state_d = DIV_FINISH;
                end
            end
            DIV_FINISH: begin
                // stall until the output is free
                if (div.out_ready) begin
                    state_d = DIV_IDLE;
                end
            end
            default: begin
                state_d = DIV_IDLE;
            end
        endcase
        // flush drops the division and its result
        if (flush_i) begin
            state_d = DIV_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cnt_q <= DIV_CNT_BITS'(DIV_CYCLES - 1);
            end else if (state_q == DIV_DIVIDE) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rem_q      <= '0;
            quo_q      <= mag_a;
            dvs_q      <= mag_b;
            // zero divisor keeps the all-ones quotient unsigned
            quo_neg_q  <= (a_neg ^ b_neg) & ~b_zero;
            // remainder takes the dividend sign, covers x/0 too
            rem_neg_q  <= a_neg;
            want_rem_q <= div.is_rem;
            id_q       <= div.id;
        end else if (state_q == DIV_DIVIDE) begin
            rem_q <= fits ? diff[XLEN-1:0] : partial[XLEN-1:0];
            // dividend bits shift out as quotient bits shift in
            quo_q <= {quo_q[XLEN-2:0], fits};
        end
    end

    // ------------------------------------------------------------------------
    // handshake and sign correction
    // ------------------------------------------------------------------------
    assign div.in_ready  = state_q == DIV_IDLE;
    assign div.out_valid = state_q == DIV_FINISH;
    assign div.out_id    = id_q;
    assign div.result    = want_rem_q ? (rem_neg_q ? -rem_q : rem_q) :
                                        (quo_neg_q ? -quo_q : quo_q);

endmodule

`default_nettype wire
